// File: Bender.yml
package:
  name: lcd_subsys

sources:
  - lcd_pkg.sv
  - lcd_fifo.sv
  - lcd_axil_regs.sv
  - lcd_dispatch.sv
  - lcd_hd44780_ctrl.sv
  - lcd_read_collect.sv
  - lcd_subsys_top.sv
  - target: test
    files:
      - lcd_subsys_properties.sv
      - tb_lcd_subsys.sv

// File: lcd_axil_regs.sv
`timescale 1ns/1ns

module lcd_axil_regs import lcd_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [4:0]              awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [31:0]             wdata,
	input  logic [3:0]              wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [4:0]              araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [31:0]             rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	output lcd_config_t             lcd_cfg,
	output logic                    start_init,
	output logic                    cmd_push,
	output lcd_cmd_t                cmd_item,
	input  logic                    cmd_full,
	output logic                    rd_pop,
	input  lcd_rd_t                 rd_item,
	input  logic                    rd_empty,
	input  logic [3:0]              rd_count,
	input  logic                    init_done,
	input  logic [lcd_channels-1:0] chan_busy
);

	logic        wr_en;
	logic        rd_en;
	logic        aw_cfg;
	logic        aw_ctrl;
	logic        aw_cmd;
	logic        wr_ok;
	logic        rd_ok;
	logic [31:0] rd_word;

	// write path, address and data taken together
	assign wr_en   = awvalid && wvalid && !bvalid;
	assign awready = wr_en;
	assign wready  = wr_en;

	assign aw_cfg  = (awaddr == reg_config);
	assign aw_ctrl = (awaddr == reg_ctrl);
	assign aw_cmd  = (awaddr == reg_cmd);
	assign wr_ok   = aw_cfg || aw_ctrl || (aw_cmd && !cmd_full);	// overflow drops the command

	assign cmd_push = wr_en && aw_cmd && !cmd_full;
	assign cmd_item = lcd_cmd_t'(wdata[11:0]);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid     <= 1'b0;
			bresp      <= resp_okay;
			lcd_cfg    <= '0;
			start_init <= 1'b0;
		end else begin
			start_init <= wr_en && aw_ctrl && wstrb[0] && wdata[0];	// one cycle pulse
			if (wr_en) begin
				bvalid <= 1'b1;
				bresp  <= wr_ok ? resp_okay : resp_slverr;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (wr_en && aw_cfg && wstrb[0]) begin
				lcd_cfg <= lcd_config_t'(wdata[6:0]);
			end
		end
	end

	// read path
	assign arready = !rvalid;
	assign rd_en   = arvalid && arready;
	assign rd_pop  = rd_en && (araddr == reg_rdata) && !rd_empty;	// empty queue is not popped
	assign rd_ok   = (araddr == reg_config) || (araddr == reg_status) || (araddr == reg_rdata);

	always_comb begin
		case (araddr)
			reg_config: rd_word = {25'd0, lcd_cfg};
			reg_status: rd_word = {20'd0, rd_count, chan_busy, 3'd0, init_done};
			reg_rdata:  rd_word = {!rd_empty, 21'd0, rd_item};	// valid flag in bit 31
			default:    rd_word = 32'd0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			rresp  <= resp_okay;
		end else begin
			if (rd_en) begin
				rvalid <= 1'b1;
				rresp  <= rd_ok ? resp_okay : resp_slverr;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rdata <= rd_word;
		end
	end

endmodule

// File: lcd_dispatch.sv
`timescale 1ns/1ns

module lcd_dispatch import lcd_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  lcd_cmd_t                head,
	input  logic                    empty,
	output logic                    pop,
	input  logic [lcd_channels-1:0] chan_ready,
	output logic [lcd_channels-1:0] start,
	output lcd_cmd_t                cmd
);

	logic target_ok;

	// a channel still shows ready during its own start cycle
	assign target_ok = chan_ready[head.chan] && !start[head.chan];

	// head of queue blocks everything behind it, keeps order
	assign pop = !empty && target_ok;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			start <= '0;
		end else begin
			start <= '0;
			if (pop) begin
				start[head.chan] <= 1'b1;
			end
		end
	end

	// shared command word, valid alongside the start pulse
	always_ff @(posedge clk) begin
		if (pop) begin
			cmd <= head;
		end
	end

endmodule

// File: lcd_fifo.sv
`timescale 1ns/1ns

module lcd_fifo #(
	parameter type item_t = logic [7:0],
	parameter int  depth  = 8	// power of two, pointers wrap naturally
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       push,
	input  item_t      wdata,
	input  logic       pop,
	output item_t      rdata,
	output logic       full,
	output logic       empty,
	output logic [3:0] count
);

	item_t                    mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic                     do_push;
	logic                     do_pop;

	assign empty   = (count == 4'd0);
	assign full    = (count == 4'(depth));
	assign do_pop  = pop && !empty;
	assign do_push = push && (!full || do_pop);	// full queue still takes a push with a pop
	assign rdata   = mem[rd_ptr];	// head shown without popping

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: lcd_hd44780_ctrl.sv
`timescale 1ns/1ns

module lcd_hd44780_ctrl import lcd_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  lcd_config_t lcd_cfg,
	input  logic        start_init,
	input  logic        start,
	input  lcd_cmd_t    cmd,
	output logic        ready,
	output lcd_pins_t   pins,
	input  logic [7:0]  din,
	output logic        rd_valid,
	output logic [7:0]  rd_data,
	input  logic        rd_ready
);

	typedef enum logic [2:0] {
		st_powerup,
		st_init,
		st_idle,
		st_xfer,
		st_rd_hold
	} state_t;

	state_t              state;
	logic [cnt_bits-1:0] cnt;
	lcd_config_t         cfg_q;
	lcd_cmd_t            cmd_q;
	logic                init_e;
	logic [7:0]          init_byte;

	assign ready    = (state == st_idle);
	assign rd_valid = (state == st_rd_hold);

	// init pulses, bus returns to zero during the waits
	always_comb begin
		init_e    = 1'b0;
		init_byte = 8'h00;
		if (cnt < c_init_p1) begin
			init_e    = 1'b1;
			init_byte = {4'b0011, cfg_q.lines, cfg_q.font, 2'b00};	// function set
		end else if (cnt >= c_init_w1 && cnt < c_init_p2) begin
			init_e    = 1'b1;
			init_byte = {5'b00001, cfg_q.display_on, cfg_q.cursor, cfg_q.blink};
		end else if (cnt >= c_init_w2 && cnt < c_init_p3) begin
			init_e    = 1'b1;
			init_byte = 8'h01;	// clear
		end else if (cnt >= c_init_w3 && cnt < c_init_p4) begin
			init_e    = 1'b1;
			init_byte = {6'b000001, cfg_q.inc_dec, cfg_q.shift};	// entry mode
		end
	end

	always_comb begin
		pins = '0;
		case (state)
			st_init: begin
				pins.e        = init_e;
				pins.data_out = init_byte;
			end
			st_xfer: begin
				pins.rs       = cmd_q.rs;	// held for the whole transfer
				pins.rw       = cmd_q.rw;
				pins.data_out = cmd_q.data;
				pins.e        = (cnt >= c_e_rise) && (cnt < c_e_fall);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_powerup;
			cnt   <= '0;
			cfg_q <= '0;
		end else begin
			case (state)
				st_powerup: begin
					if (start_init) begin
						cnt   <= cnt_bits'(1);	// nonzero cnt means the wait is running
						cfg_q <= lcd_cfg;
					end else if (cnt == c_powerup) begin
						state <= st_init;
						cnt   <= '0;
					end else if (cnt != '0) begin
						cnt <= cnt + 1'b1;
					end
				end
				st_init: begin
					if (cnt == c_init_end - 1) begin
						state <= st_idle;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_idle: begin
					if (start_init) begin
						state <= st_powerup;	// re-init with fresh config
						cnt   <= cnt_bits'(1);
						cfg_q <= lcd_cfg;
					end else if (start) begin
						state <= st_xfer;
						cnt   <= '0;
					end
				end
				st_xfer: begin
					if (cnt == c_xfer - 1) begin
						state <= cmd_q.rw ? st_rd_hold : st_idle;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_rd_hold: begin
					if (rd_ready) begin
						state <= st_idle;
					end
				end
				default: state <= st_powerup;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			cmd_q <= cmd;
		end
		// captured on the edge where e drops
		if (state == st_xfer && cmd_q.rw && cnt == c_e_fall - 1) begin
			rd_data <= din;
		end
	end

endmodule

// File: lcd_pkg.sv
package lcd_pkg;

	localparam int lcd_channels  = 4;
	localparam int lcd_chan_bits = 2;

	localparam int us_cycles = 2;	// clocks per microsecond, small for sim

	// init sequence, microseconds
	localparam int t_powerup    = 500;
	localparam int t_cmd_pulse  = 10;
	localparam int t_wait_short = 50;
	localparam int t_wait_clear = 200;
	localparam int t_wait_entry = 100;

	// byte transfer, microseconds
	localparam int t_xfer_total = 50;
	localparam int t_e_rise     = 1;
	localparam int t_e_fall     = 14;

	// same schedule in clock cycles, cumulative from init start
	localparam int c_powerup  = t_powerup * us_cycles;
	localparam int c_init_p1  = t_cmd_pulse * us_cycles;	// function set
	localparam int c_init_w1  = c_init_p1 + t_wait_short * us_cycles;
	localparam int c_init_p2  = c_init_w1 + t_cmd_pulse * us_cycles;	// display control
	localparam int c_init_w2  = c_init_p2 + t_wait_short * us_cycles;
	localparam int c_init_p3  = c_init_w2 + t_cmd_pulse * us_cycles;	// clear
	localparam int c_init_w3  = c_init_p3 + t_wait_clear * us_cycles;
	localparam int c_init_p4  = c_init_w3 + t_cmd_pulse * us_cycles;	// entry mode
	localparam int c_init_end = c_init_p4 + t_wait_entry * us_cycles;
	localparam int c_xfer     = t_xfer_total * us_cycles;
	localparam int c_e_rise   = t_e_rise * us_cycles;
	localparam int c_e_fall   = t_e_fall * us_cycles;
	localparam int cnt_bits   = $clog2(c_powerup + 1);	// power-up is the longest span

	localparam int cmd_depth = 8;
	localparam int rd_depth  = 8;

	localparam logic [4:0] reg_config = 5'h00;
	localparam logic [4:0] reg_ctrl   = 5'h04;
	localparam logic [4:0] reg_cmd    = 5'h08;
	localparam logic [4:0] reg_status = 5'h0C;
	localparam logic [4:0] reg_rdata  = 5'h10;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	typedef struct packed {
		logic lines;
		logic font;
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;
		logic shift;
	} lcd_config_t;

	typedef struct packed {
		logic [lcd_chan_bits-1:0] chan;
		logic                     rs;
		logic                     rw;
		logic [7:0]               data;
	} lcd_cmd_t;	// matches CMD bits 11:0

	typedef struct packed {
		logic [lcd_chan_bits-1:0] chan;
		logic [7:0]               data;
	} lcd_rd_t;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data_out;
	} lcd_pins_t;

endpackage

// File: lcd_read_collect.sv
`timescale 1ns/1ns

module lcd_read_collect import lcd_pkg::*; (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic [lcd_channels-1:0]      rd_valid,
	input  logic [lcd_channels-1:0][7:0] rd_data,
	output logic [lcd_channels-1:0]      rd_ready,
	output logic                         push,
	output lcd_rd_t                      item,
	input  logic                         full
);

	logic [lcd_chan_bits-1:0] ptr;	// highest priority channel
	logic [lcd_chan_bits-1:0] idx;
	logic [lcd_chan_bits-1:0] gnt_idx;
	logic                     gnt_found;

	// first valid channel at or after ptr
	always_comb begin
		gnt_found = 1'b0;
		gnt_idx   = ptr;
		idx       = ptr;
		for (int i = 0; i < lcd_channels; i++) begin
			idx = ptr + lcd_chan_bits'(i);
			if (!gnt_found && rd_valid[idx]) begin
				gnt_found = 1'b1;
				gnt_idx   = idx;
			end
		end
	end

	assign push = gnt_found && !full;	// no grant while the queue is full

	always_comb begin
		rd_ready          = '0;
		rd_ready[gnt_idx] = push;
	end

	assign item = '{chan: gnt_idx, data: rd_data[gnt_idx]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= gnt_idx + 1'b1;	// winner drops to lowest priority
		end
	end

endmodule

// File: lcd_subsys_properties.sv
`timescale 1ns/1ns

module lcd_subsys_properties import lcd_pkg::*; (
	input logic                         clk,
	input logic                         arst_n,
	input logic                         bvalid,
	input logic                         bready,
	input logic                         rvalid,
	input logic                         rready,
	input lcd_pins_t [lcd_channels-1:0] lcd_pins,
	input logic [lcd_channels-1:0]      chan_start,
	input logic [lcd_channels-1:0]      chan_ready,
	input logic [lcd_channels-1:0]      rd_valid,
	input logic [lcd_channels-1:0]      rd_ready
);

	int unsigned assert_errs = 0;	// failure count

	bvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid)
	else begin
		$error("bvalid dropped before bready");
		assert_errs++;
	end

	rvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid)
	else begin
		$error("rvalid dropped before rready");
		assert_errs++;
	end

	for (genvar ch = 0; ch < lcd_channels; ch++) begin : g_ch
		// one cycle start, only into an idle channel
		start_pulse: assert property (@(posedge clk) disable iff (!arst_n)
			chan_start[ch] |-> chan_ready[ch] ##1 !chan_start[ch])
		else begin
			$error("start on channel %0d was not a single pulse to an idle channel", ch);
			assert_errs++;
		end

		// rs and rw settle before e goes high
		e_setup: assert property (@(posedge clk) disable iff (!arst_n)
			$rose(lcd_pins[ch].e) |-> $stable(lcd_pins[ch].rs) && $stable(lcd_pins[ch].rw))
		else begin
			$error("e rose on channel %0d while rs or rw changed", ch);
			assert_errs++;
		end

		rd_held: assert property (@(posedge clk) disable iff (!arst_n)
			rd_valid[ch] && !rd_ready[ch] |=> rd_valid[ch])
		else begin
			$error("rd_valid on channel %0d dropped before rd_ready", ch);
			assert_errs++;
		end
	end

endmodule

bind lcd_subsys_top lcd_subsys_properties i_lcd_subsys_properties (
	.clk        (clk),
	.arst_n     (arst_n),
	.bvalid     (bvalid),
	.bready     (bready),
	.rvalid     (rvalid),
	.rready     (rready),
	.lcd_pins   (lcd_pins),
	.chan_start (chan_start),
	.chan_ready (chan_ready),
	.rd_valid   (rd_valid),
	.rd_ready   (rd_ready)
);

// File: lcd_subsys_top.sv
`timescale 1ns/1ns

module lcd_subsys_top import lcd_pkg::*; (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic [4:0]                   awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [31:0]                  wdata,
	input  logic [3:0]                   wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [4:0]                   araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [31:0]                  rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready,
	output lcd_pins_t [lcd_channels-1:0] lcd_pins,
	input  logic [lcd_channels-1:0][7:0] lcd_din
);

	lcd_config_t                  lcd_cfg;
	logic                         start_init;
	logic                         cmd_push;
	lcd_cmd_t                     cmd_item;
	logic                         cmd_full;
	lcd_cmd_t                     cmd_head;
	logic                         cmd_empty;
	logic                         cmd_pop;
	lcd_cmd_t                     disp_cmd;
	logic                         rd_pop;
	lcd_rd_t                      rd_item;
	logic                         rd_empty;
	logic [3:0]                   rd_count;
	logic                         rd_full;
	logic                         rd_push;
	lcd_rd_t                      rd_push_item;
	logic [lcd_channels-1:0]      chan_ready;
	logic [lcd_channels-1:0]      chan_start;
	logic [lcd_channels-1:0]      chan_busy;
	logic                         init_done;
	logic [lcd_channels-1:0]      rd_valid;
	logic [lcd_channels-1:0]      rd_ready;
	logic [lcd_channels-1:0][7:0] rd_data;

	assign init_done = &chan_ready;	// all channels through init and idle
	assign chan_busy = ~chan_ready;

	lcd_axil_regs i_lcd_axil_regs (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.lcd_cfg, .start_init,
		.cmd_push, .cmd_item, .cmd_full,
		.rd_pop, .rd_item, .rd_empty, .rd_count,
		.init_done, .chan_busy
	);

	lcd_fifo #(.item_t(lcd_cmd_t), .depth(cmd_depth)) i_cmd_fifo (
		.clk, .arst_n,
		.push(cmd_push), .wdata(cmd_item), .pop(cmd_pop), .rdata(cmd_head),
		.full(cmd_full), .empty(cmd_empty), .count()
	);

	lcd_dispatch i_lcd_dispatch (
		.clk, .arst_n,
		.head(cmd_head), .empty(cmd_empty), .pop(cmd_pop),
		.chan_ready, .start(chan_start), .cmd(disp_cmd)
	);

	for (genvar ch = 0; ch < lcd_channels; ch++) begin : g_chan
		lcd_hd44780_ctrl i_lcd_hd44780_ctrl (
			.clk, .arst_n,
			.lcd_cfg, .start_init,
			.start(chan_start[ch]), .cmd(disp_cmd), .ready(chan_ready[ch]),
			.pins(lcd_pins[ch]), .din(lcd_din[ch]),
			.rd_valid(rd_valid[ch]), .rd_data(rd_data[ch]), .rd_ready(rd_ready[ch])
		);
	end

	lcd_read_collect i_lcd_read_collect (
		.clk, .arst_n,
		.rd_valid, .rd_data, .rd_ready,
		.push(rd_push), .item(rd_push_item), .full(rd_full)
	);

	lcd_fifo #(.item_t(lcd_rd_t), .depth(rd_depth)) i_rd_fifo (
		.clk, .arst_n,
		.push(rd_push), .wdata(rd_push_item), .pop(rd_pop), .rdata(rd_item),
		.full(rd_full), .empty(rd_empty), .count(rd_count)
	);

endmodule

// File: project.f
lcd_pkg.sv
lcd_fifo.sv
lcd_axil_regs.sv
lcd_dispatch.sv
lcd_hd44780_ctrl.sv
lcd_read_collect.sv
lcd_subsys_top.sv
lcd_subsys_properties.sv
tb_lcd_subsys.sv

// File: tb_lcd_subsys.sv
`timescale 1ns/1ns

module tb_lcd_subsys import lcd_pkg::*; ();

	logic                         clk;
	logic                         arst_n;
	logic [4:0]                   awaddr;
	logic                         awvalid;
	logic                         awready;
	logic [31:0]                  wdata;
	logic [3:0]                   wstrb;
	logic                         wvalid;
	logic                         wready;
	logic [1:0]                   bresp;
	logic                         bvalid;
	logic                         bready;
	logic [4:0]                   araddr;
	logic                         arvalid;
	logic                         arready;
	logic [31:0]                  rdata;
	logic [1:0]                   rresp;
	logic                         rvalid;
	logic                         rready;
	lcd_pins_t [lcd_channels-1:0] lcd_pins;
	logic [lcd_channels-1:0][7:0] lcd_din;

	logic [9:0] exp_q  [lcd_channels][$];	// {rs, rw, data} per e pulse
	logic [9:0] got_q  [lcd_channels][$];
	logic [7:0] exp_rd [lcd_channels][$];	// read bytes still owed per channel
	int         rd_issued  [lcd_channels];
	int         reads_seen [lcd_channels];
	lcd_pins_t  last_pins  [lcd_channels];
	int         seed;
	int         errors;
	int         tests;
	int         failed;
	int         err_mark;

	lcd_subsys_top i_lcd_subsys_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// expected pin byte: init byte k for a config, or the n-th read answer of a channel
	function automatic logic [7:0] ref_byte(input bit is_read, input lcd_config_t cfg,
			input int ch, input int n);
		logic [7:0] b;
		if (is_read) begin
			b = 8'(ch * 8'h11) ^ 8'(n);
		end else begin
			case (n)
				0:       b = {4'b0011, cfg.lines, cfg.font, 2'b00};
				1:       b = {5'b00001, cfg.display_on, cfg.cursor, cfg.blink};
				2:       b = 8'h01;
				default: b = {6'b000001, cfg.inc_dec, cfg.shift};
			endcase
		end
		return b;
	endfunction

	function automatic bit pending();
		bit p;
		p = 1'b0;
		for (int c = 0; c < lcd_channels; c++) begin
			if (exp_q[c].size() != 0) begin
				p = 1'b1;
			end
		end
		return p;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("Error: %s", why);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("test %0d (%s): ok", tests, name);
		end else begin
			failed++;
			$display("test %0d (%s): %0d errors", tests, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// pin model, one word per falling e
	always @(negedge clk) begin
		for (int c = 0; c < lcd_channels; c++) begin
			if (last_pins[c].e && !lcd_pins[c].e) begin
				got_q[c].push_back({last_pins[c].rs, last_pins[c].rw, last_pins[c].data_out});
				if (last_pins[c].rw) begin
					reads_seen[c]++;
					lcd_din[c] = 8'(c * 8'h11) ^ 8'(reads_seen[c]);	// answer for next read
				end
			end
			last_pins[c] = lcd_pins[c];
		end
	end

	always @(posedge clk) begin
		for (int c = 0; c < lcd_channels; c++) begin
			while (exp_q[c].size() != 0 && got_q[c].size() != 0) begin
				check($sformatf("lcd_pins[%0d]", c), 32'(got_q[c].pop_front()),
					32'(exp_q[c].pop_front()));
			end
		end
	end

	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int gap;
		n = 0;
		@(negedge clk);
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wstrb   = 4'hf;
		wvalid  = 1'b1;
		@(posedge clk);
		while (!awready) begin
			if (n == 100) begin
				abort_run("write address was never accepted by the DUT");
			end
			n++;
			@(posedge clk);
		end
		check("wready", wready, 1'b1);	// data taken with the address
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		check("bvalid", bvalid, 1'b1);	// response one cycle after acceptance
		resp    = bresp;
		gap     = $random(seed) & 3;	// let bvalid wait a little
		repeat (gap) @(negedge clk);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int gap;
		n = 0;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		@(posedge clk);
		while (!arready) begin
			if (n == 100) begin
				abort_run("read address was never accepted by the DUT");
			end
			n++;
			@(posedge clk);
		end
		@(negedge clk);
		arvalid = 1'b0;
		check("rvalid", rvalid, 1'b1);	// data one cycle after the address
		data    = rdata;
		resp    = rresp;
		gap     = $random(seed) & 3;
		repeat (gap) @(negedge clk);
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// retries while the command queue is full
	task automatic send_cmd(input logic [1:0] ch, input logic rs, input logic rw,
			input logic [7:0] dbyte);
		logic [1:0] resp;
		int         tries;
		tries = 0;
		axi_write(reg_cmd, {20'd0, ch, rs, rw, dbyte}, resp);
		while (resp != resp_okay) begin
			if (tries == 100) begin
				abort_run("command queue never accepted a command");
			end
			tries++;
			repeat (20) @(negedge clk);
			axi_write(reg_cmd, {20'd0, ch, rs, rw, dbyte}, resp);
		end
		exp_q[ch].push_back({rs, rw, dbyte});
		if (rw) begin
			exp_rd[ch].push_back(ref_byte(1'b1, '0, ch, rd_issued[ch]));
			rd_issued[ch]++;
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (pending()) begin
			if (n == limit) begin
				abort_run("expected e pulses never showed up at the pins");
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic wait_idle();
		logic [31:0] d;
		logic [1:0]  resp;
		int          n;
		n = 0;
		axi_read(reg_status, d, resp);
		while (!d[0] || d[7:4] != 4'h0) begin
			if (n == 200) begin
				abort_run("channels stayed busy");
			end
			n++;
			repeat (10) @(negedge clk);
			axi_read(reg_status, d, resp);
		end
	endtask

	task automatic check_no_extra();
		for (int c = 0; c < lcd_channels; c++) begin
			check($sformatf("lcd_pins[%0d] extra pulses", c), got_q[c].size(), 0);
		end
	endtask

	initial begin
		lcd_config_t cfg;
		logic [31:0] d;
		logic [1:0]  resp;
		logic [1:0]  ch;
		logic        rs;
		logic [7:0]  dbyte;
		int          n_err;
		int          a_errs;
		seed     = 32'h576c_dbcc;
		errors   = 0;
		tests    = 0;
		failed   = 0;
		err_mark = 0;
		arst_n   = 1'b0;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		for (int c = 0; c < lcd_channels; c++) begin
			lcd_din[c]    = 8'(c * 8'h11);
			last_pins[c]  = '0;
			rd_issued[c]  = 0;
			reads_seen[c] = 0;
		end
		repeat (4) @(negedge clk);
		arst_n = 1'b1;

		axi_read(reg_status, d, resp);
		check("status", d, 32'h0000_00f0);	// all busy, not initialized
		repeat (20) @(negedge clk);
		check_no_extra();
		end_test("reset state");

		cfg = 7'($random(seed));
		axi_write(reg_config, {25'd0, cfg}, resp);
		check("bresp", resp, resp_okay);
		for (int c = 0; c < lcd_channels; c++) begin
			for (int k = 0; k < 4; k++) begin
				exp_q[c].push_back({2'b00, ref_byte(1'b0, cfg, c, k)});
			end
		end
		axi_write(reg_ctrl, 32'd1, resp);
		wait_drained(4000);
		wait_idle();
		axi_read(reg_status, d, resp);
		check("status", d, 32'h0000_0001);
		axi_read(reg_config, d, resp);
		check("config", d, {25'd0, cfg});
		check_no_extra();
		end_test("init sequence");

		for (int k = 0; k < 40; k++) begin
			ch    = 2'($random(seed));
			rs    = 1'($random(seed));
			dbyte = 8'($random(seed));
			send_cmd(ch, rs, 1'b0, dbyte);
		end
		wait_drained(8000);
		wait_idle();
		check_no_extra();
		end_test("random writes");

		for (int k = 0; k < 6; k++) begin
			ch    = 2'($random(seed));
			rs    = 1'($random(seed));
			dbyte = 8'($random(seed));
			send_cmd(ch, rs, 1'b1, dbyte);
		end
		wait_drained(2000);
		wait_idle();
		axi_read(reg_status, d, resp);
		check("status", d, 32'h0000_0601);	// six results queued
		for (int k = 0; k < 6; k++) begin
			axi_read(reg_rdata, d, resp);
			ch = d[9:8];
			if (!d[31] || exp_rd[ch].size() == 0) begin
				errors++;
				$display("Error: RDATA entry %0d has no matching read result", k);
			end else begin
				check("rdata", d, {1'b1, 21'd0, ch, exp_rd[ch].pop_front()});
			end
		end
		axi_read(reg_rdata, d, resp);
		check("rdata valid flag", d[31], 1'b0);	// queue now empty
		check("rresp", resp, resp_okay);
		check_no_extra();
		end_test("reads");

		n_err = 0;
		for (int k = 0; k < 16; k++) begin
			rs    = 1'($random(seed));
			dbyte = 8'($random(seed));
			axi_write(reg_cmd, {20'd0, 2'd1, rs, 1'b0, dbyte}, resp);
			if (resp == resp_okay) begin
				exp_q[1].push_back({rs, 1'b0, dbyte});
			end else begin
				n_err++;
			end
		end
		check("overflow slverr seen", n_err != 0, 1);
		wait_drained(4000);
		wait_idle();
		check_no_extra();
		end_test("queue overflow");

		axi_write(5'h14, 32'h0000_00ff, resp);
		check("bresp", resp, resp_slverr);
		axi_read(5'h18, d, resp);
		check("rresp", resp, resp_slverr);
		repeat (20) @(negedge clk);
		check_no_extra();
		end_test("unmapped address");

		a_errs = i_lcd_subsys_top.i_lcd_subsys_properties.assert_errs;
		$display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
			tests, failed, errors, a_errs);
		if (errors == 0 && a_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
